// ==== npc_macros.svh ====
`ifndef NPC_MACROS_SVH
`define NPC_MACROS_SVH

// reset state
`define NPC_RESET_PC       64'h0000_0000_8000_0000
`define NPC_MSTATUS_RESET  64'ha00001800
`define NPC_GPR_NUM        32

// major opcodes of the executed subset
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_SYSTEM  7'b1110011

// funct fields
`define F3_ADD      3'b000
`define F3_BEQ      3'b000
`define F3_PRIV     3'b000
`define F3_CSRRW    3'b001
`define F7_ADD      7'b0000000
`define F7_SUB      7'b0100000
`define F12_ECALL   12'h000
`define F12_MRET    12'h302

// machine csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// mstatus fields
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP  12:11

// trap causes
`define CAUSE_ILLEGAL 64'd2
`define CAUSE_ECALL_M 64'd11

`endif

// ==== npc_pkg.sv ====
package npc_pkg;

	//**************************************************
	// word types
	//**************************************************

	// data and address word of the rv64 core
	typedef logic [63:0] xlen_t;

	// one fetched instruction
	typedef logic [31:0] inst_t;

	// general register index, x0 to x31
	typedef logic [4:0] reg_idx_t;

	// machine csr address space
	typedef logic [11:0] csr_addr_t;

	//**************************************************
	// fetch fsm
	//**************************************************

	// idle until exu hands back the next pc
	// request holds fetch_req up until the ack
	// issue presents the captured word for one cycle
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,
		FETCH_ISSUE
	} fetch_state_t;

endpackage

// ==== npc_regfile.sv ====
`include "npc_macros.svh"

module npc_regfile import npc_pkg::*; (
	input  logic     clk,

	// read ports
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output xlen_t    rs1_data,
	output xlen_t    rs2_data,

	// write port
	input  reg_idx_t rd,
	input  logic     rd_wen,
	input  xlen_t    rd_data
);

	//**************************************************
	// general register array
	//**************************************************

	xlen_t gpr [`NPC_GPR_NUM];

	// x0 is hardwired, never written
	always_ff @(posedge clk) begin
		if (rd_wen && (rd != '0)) begin
			gpr[rd] <= rd_data;
		end
	end

	// combinational reads
	// index zero forced to zero since gpr[0] never gets a value
	assign rs1_data = (rs1 == '0) ? '0 : gpr[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : gpr[rs2];

endmodule

// ==== npc_csr.sv ====
`include "npc_macros.svh"

module npc_csr import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// plain csr access from exu
	input  csr_addr_t csr_addr,
	input  logic      csr_wen,
	input  xlen_t     csr_wdata,
	output xlen_t     csr_rdata,

	// trap entry and return
	input  logic      trap_take,
	input  xlen_t     trap_cause,
	input  xlen_t     trap_pc,
	input  logic      mret_take,

	// for next pc selection
	output xlen_t     mtvec,
	output xlen_t     mepc
);

	xlen_t mcause;
	xlen_t mstatus;

	//**************************************************
	// register update
	//**************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
			mstatus <= `NPC_MSTATUS_RESET;
		end else if (trap_take) begin
			// trap entry wins over any plain write
			mepc                  <= trap_pc;
			mcause                <= trap_cause;
			mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
			mstatus[`MSTATUS_MIE]  <= 1'b0;
			// previous mode is always machine here
			mstatus[`MSTATUS_MPP]  <= 2'b11;
		end else if (mret_take) begin
			mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
			mstatus[`MSTATUS_MPIE] <= 1'b1;
		end else if (csr_wen) begin
			case (csr_addr)
				`CSR_MTVEC:   mtvec   <= csr_wdata;
				`CSR_MEPC:    mepc    <= csr_wdata;
				`CSR_MCAUSE:  mcause  <= csr_wdata;
				`CSR_MSTATUS: mstatus <= csr_wdata;
				default: ;
			endcase
		end
	end

	//**************************************************
	// address decoded read
	//**************************************************

	always_comb begin
		case (csr_addr)
			`CSR_MTVEC:   csr_rdata = mtvec;
			`CSR_MEPC:    csr_rdata = mepc;
			`CSR_MCAUSE:  csr_rdata = mcause;
			`CSR_MSTATUS: csr_rdata = mstatus;
			default:      csr_rdata = '0;
		endcase
	end

endmodule

// ==== npc_ifu.sv ====
`include "npc_macros.svh"

module npc_ifu import npc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,

	// instruction memory side
	output logic  fetch_req,
	output xlen_t fetch_addr,
	input  logic  fetch_ack,
	input  inst_t fetch_inst,

	// current fetch pc
	output xlen_t pc,

	// to exu
	output logic  inst_valid,
	output inst_t inst,
	output xlen_t inst_pc,

	// next pc from exu
	input  logic  pc_update,
	input  xlen_t dnpc
);

	fetch_state_t state;
	xlen_t        pc_q;
	// first request after reset needs no pc_update
	logic         boot;

	//**************************************************
	// fetch fsm
	//**************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FETCH_IDLE;
			pc_q  <= `NPC_RESET_PC;
			boot  <= 1'b1;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (boot) begin
						boot  <= 1'b0;
						state <= FETCH_REQUEST;
					end else if (pc_update) begin
						pc_q  <= dnpc;
						state <= FETCH_REQUEST;
					end
				end
				// address held until memory acks
				FETCH_REQUEST: begin
					if (fetch_ack) begin
						state <= FETCH_ISSUE;
					end
				end
				// one cycle issue then wait for exu
				FETCH_ISSUE: state <= FETCH_IDLE;
				default:     state <= FETCH_IDLE;
			endcase
		end
	end

	// capture word and its pc on the ack cycle
	always_ff @(posedge clk) begin
		if ((state == FETCH_REQUEST) && fetch_ack) begin
			inst    <= fetch_inst;
			inst_pc <= pc_q;
		end
	end

	assign fetch_req  = (state == FETCH_REQUEST);
	assign fetch_addr = pc_q;
	assign pc         = pc_q;
	assign inst_valid = (state == FETCH_ISSUE);

endmodule

// ==== npc_exu.sv ====
`include "npc_macros.svh"

module npc_exu import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// from ifu
	input  logic      inst_valid,
	input  inst_t     inst,
	input  xlen_t     inst_pc,

	// register file
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	input  xlen_t     rs1_data,
	input  xlen_t     rs2_data,
	output reg_idx_t  rd,
	output logic      rd_wen,
	output xlen_t     rd_data,

	// csr block
	output csr_addr_t csr_addr,
	output logic      csr_wen,
	output xlen_t     csr_wdata,
	input  xlen_t     csr_rdata,
	output logic      trap_take,
	output xlen_t     trap_cause,
	output xlen_t     trap_pc,
	output logic      mret_take,
	input  xlen_t     mtvec,
	input  xlen_t     mepc,

	// next pc back to ifu
	output logic      pc_update,
	output xlen_t     dnpc,

	// commit report
	output logic      wb_valid,
	output xlen_t     wb_pc,
	output reg_idx_t  wb_rd,
	output xlen_t     wb_data
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd_idx;
	xlen_t      imm_i;
	xlen_t      imm_u;
	xlen_t      imm_b;
	xlen_t      snpc;
	logic       csr_known;
	logic       sys_zero;

	logic       illegal;
	logic       is_ecall;
	logic       is_mret;
	logic       is_trap;
	logic       gpr_wen;
	logic       csr_we;
	logic       commit_wen;
	xlen_t      gpr_data;
	xlen_t      next_pc;

	//**************************************************
	// field extraction
	//**************************************************

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rd_idx   = inst[11:7];
	assign rs1      = inst[19:15];
	assign rs2      = inst[24:20];
	// inst stays put through the commit cycle, so this also serves the write
	assign csr_addr = inst[31:20];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign snpc  = inst_pc + 64'd4;

	// only the four implemented csrs
	assign csr_known = (csr_addr == `CSR_MTVEC) || (csr_addr == `CSR_MEPC) ||
		(csr_addr == `CSR_MCAUSE) || (csr_addr == `CSR_MSTATUS);
	// rs1, funct3 and rd all zero for ecall and mret
	assign sys_zero = (inst[19:7] == '0);

	//**************************************************
	// decode and execute
	//**************************************************

	always_comb begin
		illegal  = 1'b0;
		is_ecall = 1'b0;
		is_mret  = 1'b0;
		gpr_wen  = 1'b0;
		csr_we   = 1'b0;
		gpr_data = '0;
		next_pc  = snpc;
		case (opcode)
			`OPC_OP_IMM: begin
				if (funct3 == `F3_ADD) begin
					gpr_wen  = 1'b1;
					gpr_data = rs1_data + imm_i;
				end else begin
					illegal = 1'b1;
				end
			end
			`OPC_OP: begin
				if ((funct3 == `F3_ADD) && (funct7 == `F7_ADD)) begin
					gpr_wen  = 1'b1;
					gpr_data = rs1_data + rs2_data;
				end else if ((funct3 == `F3_ADD) && (funct7 == `F7_SUB)) begin
					gpr_wen  = 1'b1;
					gpr_data = rs1_data - rs2_data;
				end else begin
					illegal = 1'b1;
				end
			end
			`OPC_LUI: begin
				gpr_wen  = 1'b1;
				gpr_data = imm_u;
			end
			`OPC_BRANCH: begin
				if (funct3 != `F3_BEQ) begin
					illegal = 1'b1;
				end else if (rs1_data == rs2_data) begin
					next_pc = inst_pc + imm_b;
				end
			end
			`OPC_SYSTEM: begin
				if ((funct3 == `F3_CSRRW) && csr_known) begin
					// old csr value goes to rd
					gpr_wen  = 1'b1;
					gpr_data = csr_rdata;
					csr_we   = 1'b1;
				end else if (sys_zero && (csr_addr == `F12_ECALL)) begin
					is_ecall = 1'b1;
				end else if (sys_zero && (csr_addr == `F12_MRET)) begin
					is_mret = 1'b1;
					next_pc = mepc;
				end else begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
		endcase
		is_trap = illegal || is_ecall;
		// vector to mtvec with low bits cleared
		if (is_trap) begin
			next_pc = {mtvec[63:2], 2'b00};
		end
	end

	// x0 writes report as no write
	assign commit_wen = gpr_wen && (rd_idx != '0);

	//**************************************************
	// commit registers
	//**************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid  <= 1'b0;
			pc_update <= 1'b0;
			rd_wen    <= 1'b0;
			csr_wen   <= 1'b0;
			trap_take <= 1'b0;
			mret_take <= 1'b0;
		end else begin
			wb_valid  <= inst_valid;
			pc_update <= inst_valid;
			rd_wen    <= inst_valid && commit_wen;
			csr_wen   <= inst_valid && csr_we;
			trap_take <= inst_valid && is_trap;
			mret_take <= inst_valid && is_mret;
		end
	end

	// payload only loads with a new instruction
	always_ff @(posedge clk) begin
		if (inst_valid) begin
			dnpc       <= next_pc;
			wb_pc      <= inst_pc;
			wb_rd      <= commit_wen ? rd_idx : '0;
			wb_data    <= commit_wen ? gpr_data : '0;
			csr_wdata  <= rs1_data;
			trap_cause <= is_ecall ? `CAUSE_ECALL_M : `CAUSE_ILLEGAL;
		end
	end

	// write port and trap pc come straight from the commit report
	assign rd      = wb_rd;
	assign rd_data = wb_data;
	assign trap_pc = wb_pc;

endmodule

// ==== npc_top.sv ====
module npc_top import npc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	// instruction memory
	output logic     fetch_req,
	output xlen_t    fetch_addr,
	input  logic     fetch_ack,
	input  inst_t    fetch_inst,

	output xlen_t    pc,

	// commit report
	output logic     wb_valid,
	output xlen_t    wb_pc,
	output reg_idx_t wb_rd,
	output xlen_t    wb_data
);

	//**************************************************
	// ifu to exu
	//**************************************************

	logic      inst_valid;
	inst_t     inst;
	xlen_t     inst_pc;
	logic      pc_update;
	xlen_t     dnpc;

	npc_ifu u_ifu (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_ack  (fetch_ack),
		.fetch_inst (fetch_inst),
		.pc         (pc),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.pc_update  (pc_update),
		.dnpc       (dnpc)
	);

	//**************************************************
	// general registers
	//**************************************************

	reg_idx_t  rs1;
	reg_idx_t  rs2;
	xlen_t     rs1_data;
	xlen_t     rs2_data;
	reg_idx_t  rd;
	logic      rd_wen;
	xlen_t     rd_data;

	npc_regfile u_regfile (
		.clk      (clk),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.rd       (rd),
		.rd_wen   (rd_wen),
		.rd_data  (rd_data)
	);

	//**************************************************
	// machine csrs
	//**************************************************

	csr_addr_t csr_addr;
	logic      csr_wen;
	xlen_t     csr_wdata;
	xlen_t     csr_rdata;
	logic      trap_take;
	xlen_t     trap_cause;
	xlen_t     trap_pc;
	logic      mret_take;
	xlen_t     mtvec;
	xlen_t     mepc;

	npc_csr u_csr (
		.clk        (clk),
		.rst_n      (rst_n),
		.csr_addr   (csr_addr),
		.csr_wen    (csr_wen),
		.csr_wdata  (csr_wdata),
		.csr_rdata  (csr_rdata),
		.trap_take  (trap_take),
		.trap_cause (trap_cause),
		.trap_pc    (trap_pc),
		.mret_take  (mret_take),
		.mtvec      (mtvec),
		.mepc       (mepc)
	);

	// execute and write back
	npc_exu u_exu (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.rs1        (rs1),
		.rs2        (rs2),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.rd         (rd),
		.rd_wen     (rd_wen),
		.rd_data    (rd_data),
		.csr_addr   (csr_addr),
		.csr_wen    (csr_wen),
		.csr_wdata  (csr_wdata),
		.csr_rdata  (csr_rdata),
		.trap_take  (trap_take),
		.trap_cause (trap_cause),
		.trap_pc    (trap_pc),
		.mret_take  (mret_take),
		.mtvec      (mtvec),
		.mepc       (mepc),
		.pc_update  (pc_update),
		.dnpc       (dnpc),
		.wb_valid   (wb_valid),
		.wb_pc      (wb_pc),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

endmodule

// ==== npc_chk.sv ====
`include "npc_macros.svh"

module npc_chk import npc_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     fetch_req,
	input xlen_t    fetch_addr,
	input logic     fetch_ack,
	input inst_t    fetch_inst,
	input xlen_t    pc,
	input logic     wb_valid,
	input xlen_t    wb_pc,
	input reg_idx_t wb_rd,
	input xlen_t    wb_data
);

	// bumped by every failing assertion, read back by the testbench
	int           fail_count = 0;
	logic         seen_rst = 1'b0;
	fetch_state_t fst;
	logic         boot;
	logic [1:0]   ack_pipe;

	// shadow architectural state
	inst_t        cap;
	xlen_t        cap_pc;
	xlen_t        sh_pc;
	xlen_t        sgpr [32];
	xlen_t        s_mtvec;
	xlen_t        s_mepc;
	xlen_t        s_mcause;
	xlen_t        s_mstatus;

	// expected effect of the captured word
	xlen_t        a;
	xlen_t        b;
	xlen_t        csr_old;
	logic         csr_hit;
	logic         e_wen;
	logic         e_csrw;
	logic         e_trap;
	logic         e_mret;
	xlen_t        e_cause;
	xlen_t        e_val;
	xlen_t        e_npc;
	reg_idx_t     e_rd;
	xlen_t        e_data;

	//**************************************************
	// reference decode from the isa rules
	//**************************************************

	always_comb begin
		a = (cap[19:15] == 5'd0) ? 64'd0 : sgpr[cap[19:15]];
		b = (cap[24:20] == 5'd0) ? 64'd0 : sgpr[cap[24:20]];
		csr_hit = 1'b1;
		case (cap[31:20])
			`CSR_MTVEC:   csr_old = s_mtvec;
			`CSR_MEPC:    csr_old = s_mepc;
			`CSR_MCAUSE:  csr_old = s_mcause;
			`CSR_MSTATUS: csr_old = s_mstatus;
			default: begin
				csr_old = 64'd0;
				csr_hit = 1'b0;
			end
		endcase
		e_wen   = 1'b0;
		e_csrw  = 1'b0;
		e_trap  = 1'b0;
		e_mret  = 1'b0;
		e_cause = `CAUSE_ILLEGAL;
		e_val   = 64'd0;
		e_npc   = cap_pc + 64'd4;
		case (cap[6:0])
			`OPC_OP_IMM: begin
				e_wen  = (cap[14:12] == 3'b000);
				e_trap = !e_wen;
				e_val  = a + {{52{cap[31]}}, cap[31:20]};
			end
			`OPC_OP: begin
				if ((cap[14:12] == 3'b000) && (cap[31:25] == 7'h00)) begin
					e_wen = 1'b1;
					e_val = a + b;
				end else if ((cap[14:12] == 3'b000) && (cap[31:25] == 7'h20)) begin
					e_wen = 1'b1;
					e_val = a - b;
				end else begin
					e_trap = 1'b1;
				end
			end
			`OPC_LUI: begin
				e_wen = 1'b1;
				e_val = {{32{cap[31]}}, cap[31:12], 12'h000};
			end
			`OPC_BRANCH: begin
				if (cap[14:12] != 3'b000) begin
					e_trap = 1'b1;
				end else if (a == b) begin
					e_npc = cap_pc + {{51{cap[31]}}, cap[31], cap[7], cap[30:25], cap[11:8], 1'b0};
				end
			end
			`OPC_SYSTEM: begin
				// ecall and mret matched on the full word
				if (cap == 32'h0000_0073) begin
					e_trap  = 1'b1;
					e_cause = `CAUSE_ECALL_M;
				end else if (cap == 32'h3020_0073) begin
					e_mret = 1'b1;
					e_npc  = s_mepc;
				end else if ((cap[14:12] == 3'b001) && csr_hit) begin
					e_wen  = 1'b1;
					e_csrw = 1'b1;
					e_val  = csr_old;
				end else begin
					e_trap = 1'b1;
				end
			end
			default: e_trap = 1'b1;
		endcase
		if (e_trap) begin
			e_npc = {s_mtvec[63:2], 2'b00};
		end
		e_rd   = (e_wen && (cap[11:7] != 5'd0)) ? cap[11:7] : 5'd0;
		e_data = (e_rd != 5'd0) ? e_val : 64'd0;
	end

	//**************************************************
	// shadow state update
	//**************************************************

	always @(posedge clk) begin
		if (!rst_n) begin
			seen_rst  <= 1'b1;
			fst       <= FETCH_IDLE;
			boot      <= 1'b1;
			ack_pipe  <= 2'b00;
			sh_pc     <= `NPC_RESET_PC;
			s_mtvec   <= 64'd0;
			s_mepc    <= 64'd0;
			s_mcause  <= 64'd0;
			s_mstatus <= `NPC_MSTATUS_RESET;
		end else begin
			ack_pipe <= {ack_pipe[0], fetch_req && fetch_ack};
			// expected fetch protocol
			case (fst)
				FETCH_IDLE: begin
					if (boot) begin
						boot <= 1'b0;
						fst  <= FETCH_REQUEST;
					end else if (wb_valid) begin
						fst <= FETCH_REQUEST;
					end
				end
				FETCH_REQUEST: begin
					if (fetch_ack) begin
						fst <= FETCH_ISSUE;
					end
				end
				default: fst <= FETCH_IDLE;
			endcase
			if (fetch_req && fetch_ack) begin
				cap    <= fetch_inst;
				cap_pc <= fetch_addr;
			end
			// retire the captured word
			if (wb_valid) begin
				sh_pc <= e_npc;
				if (e_rd != 5'd0) begin
					sgpr[e_rd] <= e_val;
				end
				if (e_trap) begin
					s_mepc                   <= cap_pc;
					s_mcause                 <= e_cause;
					s_mstatus[`MSTATUS_MPIE] <= s_mstatus[`MSTATUS_MIE];
					s_mstatus[`MSTATUS_MIE]  <= 1'b0;
					s_mstatus[`MSTATUS_MPP]  <= 2'b11;
				end else if (e_mret) begin
					s_mstatus[`MSTATUS_MIE]  <= s_mstatus[`MSTATUS_MPIE];
					s_mstatus[`MSTATUS_MPIE] <= 1'b1;
				end else if (e_csrw) begin
					case (cap[31:20])
						`CSR_MTVEC:   s_mtvec   <= a;
						`CSR_MEPC:    s_mepc    <= a;
						`CSR_MCAUSE:  s_mcause  <= a;
						`CSR_MSTATUS: s_mstatus <= a;
						default: ;
					endcase
				end
			end
		end
	end

	//**************************************************
	// assertions
	//**************************************************

	// quiet outputs once reset has been held a full cycle
	a_reset: assert property (@(posedge clk)
		(seen_rst && !rst_n && !$past(rst_n)) |->
		(!fetch_req && !wb_valid && (pc == `NPC_RESET_PC)))
		else begin
			$error("outputs not idle during reset");
			fail_count++;
		end

	a_req_shape: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req == (fst == FETCH_REQUEST))
		else begin
			$error("fetch_req out of step with the fetch protocol");
			fail_count++;
		end

	// request and address held until ack
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(fetch_req && !fetch_ack) |=> (fetch_req && $stable(fetch_addr)))
		else begin
			$error("fetch request dropped or address moved before ack");
			fail_count++;
		end

	// covers reset pc, branches, trap vector and mret
	a_fetch_pc: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> (fetch_addr == sh_pc))
		else begin
			$error("fetch_addr %h, shadow pc %h", fetch_addr, sh_pc);
			fail_count++;
		end

	a_commit_delay: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid == ack_pipe[1])
		else begin
			$error("wb_valid not two cycles after fetch_ack");
			fail_count++;
		end

	a_commit: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> ((wb_pc == cap_pc) && (wb_rd == e_rd) && (wb_data == e_data)))
		else begin
			$error("commit at %h: rd %0d data %h, shadow rd %0d data %h",
				wb_pc, wb_rd, wb_data, e_rd, e_data);
			fail_count++;
		end

endmodule

bind npc_top npc_chk u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.fetch_req  (fetch_req),
	.fetch_addr (fetch_addr),
	.fetch_ack  (fetch_ack),
	.fetch_inst (fetch_inst),
	.pc         (pc),
	.wb_valid   (wb_valid),
	.wb_pc      (wb_pc),
	.wb_rd      (wb_rd),
	.wb_data    (wb_data)
);

// ==== npc_tb.sv ====
`include "npc_macros.svh"

module npc_tb import npc_pkg::*; ();

	// executed instructions per test, sets the run limit
	localparam int TOTAL_INST = 9 + 12 + 16 + 8;
	localparam int MAX_CYCLES = TOTAL_INST * 8 + 4 * (20 + 4);

	logic     clk = 1'b0;
	logic     rst_n = 1'b0;
	logic     fetch_req;
	xlen_t    fetch_addr;
	logic     fetch_ack = 1'b0;
	inst_t    fetch_inst = 32'h0;
	xlen_t    pc;
	logic     wb_valid;
	xlen_t    wb_pc;
	reg_idx_t wb_rd;
	xlen_t    wb_data;

	// program image, 64 words from the reset pc
	inst_t    prog [64];
	integer   seed = 58504;
	logic     busy = 1'b0;
	int       delay = 0;
	int       cycle_count = 0;
	logic     timed_out = 1'b0;
	int       passes = 0;
	int       fails = 0;

	npc_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_ack  (fetch_ack),
		.fetch_inst (fetch_inst),
		.pc         (pc),
		.wb_valid   (wb_valid),
		.wb_pc      (wb_pc),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	always #50 clk = ~clk;

	//**************************************************
	// instruction memory responder
	//**************************************************

	// ack after 0 to 3 extra cycles
	always @(posedge clk) begin
		#1;
		if (!rst_n || fetch_ack) begin
			fetch_ack = 1'b0;
			busy      = 1'b0;
		end else begin
			if (fetch_req && !busy) begin
				busy  = 1'b1;
				delay = $unsigned($random(seed)) % 4;
			end
			if (busy) begin
				if (delay == 0) begin
					fetch_ack  = 1'b1;
					fetch_inst = prog[fetch_addr[7:2]];
				end else begin
					delay--;
				end
			end
		end
	end

	// run watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", MAX_CYCLES);
			timed_out = 1'b1;
			finish_run();
		end
	end

	//**************************************************
	// instruction encoders
	//**************************************************

	function automatic inst_t addi(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, `F3_ADD, rd, `OPC_OP_IMM};
	endfunction

	function automatic inst_t alu_rr(input logic [6:0] f7, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		return {f7, rs2, rs1, `F3_ADD, rd, `OPC_OP};
	endfunction

	function automatic inst_t lui(input reg_idx_t rd, input logic [19:0] imm);
		return {imm, rd, `OPC_LUI};
	endfunction

	function automatic inst_t beq(input reg_idx_t rs1, input reg_idx_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, `F3_BEQ, off[4:1], off[11], `OPC_BRANCH};
	endfunction

	function automatic inst_t csrrw(input reg_idx_t rd, input csr_addr_t csr, input reg_idx_t rs1);
		return {csr, rs1, `F3_CSRRW, rd, `OPC_SYSTEM};
	endfunction

	// nop carrying its own slot number
	task automatic clear_prog();
		for (int i = 0; i < 64; i++) begin
			prog[i] = addi(5'd0, 5'd0, i[11:0]);
		end
	endtask

	// mtvec = 0x80000040 without sign extension
	task automatic load_vector_setup();
		prog[0] = lui(5'd1, 20'h40000);
		prog[1] = alu_rr(`F7_ADD, 5'd1, 5'd1, 5'd1);
		prog[2] = addi(5'd1, 5'd1, 12'h040);
		prog[3] = csrrw(5'd0, `CSR_MTVEC, 5'd1);
	endtask

	//**************************************************
	// test sequencing
	//**************************************************

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic run_prog(input string name, input int n_inst, input xlen_t marker,
		input reg_idx_t exp_rd, input xlen_t exp_data);
		int   cycles;
		int   err_start;
		logic done;
		apply_reset();
		err_start = DUT.u_chk.fail_count;
		cycles = 0;
		done = 1'b0;
		// wait for the marker commit
		while (!done && (cycles < n_inst * 8 + 20)) begin
			@(posedge clk);
			#2;
			cycles++;
			done = wb_valid && (wb_pc == marker);
		end
		if (!done) begin
			$display("%s: no commit at pc %h within %0d cycles", name, marker, cycles);
			fails++;
		end else if ((wb_rd !== exp_rd) || (wb_data !== exp_data)) begin
			$display("ERROR %s: expected x%0d = %h, actual x%0d = %h",
				name, exp_rd, exp_data, wb_rd, wb_data);
			fails++;
		end else if (DUT.u_chk.fail_count != err_start) begin
			$display("%s: %0d assertion failures during the test",
				name, DUT.u_chk.fail_count - err_start);
			fails++;
		end else begin
			$display("%s: passed", name);
			passes++;
		end
	endtask

	task automatic finish_run();
		int asserts;
		asserts = DUT.u_chk.fail_count;
		$display("tests passed %0d, failed %0d, assertion failures %0d", passes, fails, asserts);
		if ((fails == 0) && (asserts == 0) && !timed_out) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	endtask

	initial begin
		// alu, with a write to x0 and a read of it
		clear_prog();
		prog[0] = addi(5'd1, 5'd0, 12'd5);
		prog[1] = addi(5'd2, 5'd0, 12'hffd);
		prog[2] = alu_rr(`F7_ADD, 5'd3, 5'd1, 5'd2);
		prog[3] = alu_rr(`F7_SUB, 5'd4, 5'd1, 5'd2);
		prog[4] = lui(5'd5, 20'h12345);
		prog[5] = addi(5'd0, 5'd1, 12'd7);
		prog[6] = alu_rr(`F7_ADD, 5'd6, 5'd0, 5'd5);
		prog[7] = lui(5'd7, 20'h80000);
		prog[8] = alu_rr(`F7_SUB, 5'd8, 5'd7, 5'd3);
		run_prog("alu", 9, `NPC_RESET_PC + 64'h20, 5'd8, 64'hffff_ffff_7fff_fffe);

		// taken, not taken and backward branches
		clear_prog();
		prog[0]  = addi(5'd1, 5'd0, 12'd9);
		prog[1]  = addi(5'd2, 5'd0, 12'd9);
		prog[2]  = beq(5'd1, 5'd2, 13'd12);
		prog[3]  = addi(5'd10, 5'd0, 12'd1);
		prog[4]  = addi(5'd10, 5'd0, 12'd2);
		prog[5]  = addi(5'd3, 5'd0, 12'd4);
		prog[6]  = beq(5'd1, 5'd3, 13'd8);
		prog[7]  = addi(5'd11, 5'd0, 12'd33);
		prog[8]  = beq(5'd0, 5'd0, 13'd12);
		prog[9]  = addi(5'd11, 5'd0, 12'd99);
		prog[10] = addi(5'd12, 5'd11, 12'd1);
		prog[11] = beq(5'd0, 5'd0, 13'h1ffc);
		run_prog("branch", 12, `NPC_RESET_PC + 64'h28, 5'd12, 64'd34);

		// ecall twice through the handler, second pass exits
		clear_prog();
		load_vector_setup();
		prog[4]  = addi(5'd9, 5'd0, 12'd0);
		prog[5]  = addi(5'd8, 5'd0, 12'd2);
		prog[6]  = {`F12_ECALL, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM};
		prog[7]  = addi(5'd20, 5'd0, 12'd1);
		prog[16] = addi(5'd9, 5'd9, 12'd1);
		prog[17] = beq(5'd9, 5'd8, 13'd12);
		prog[18] = {`F12_MRET, 5'd0, `F3_PRIV, 5'd0, `OPC_SYSTEM};
		prog[19] = addi(5'd21, 5'd0, 12'd1);
		prog[20] = csrrw(5'd5, `CSR_MCAUSE, 5'd0);
		run_prog("trap", 16, `NPC_RESET_PC + 64'h50, 5'd5, 64'd11);

		// unknown opcode traps to the same vector
		clear_prog();
		load_vector_setup();
		prog[4]  = 32'hffff_ffff;
		prog[16] = csrrw(5'd5, `CSR_MCAUSE, 5'd0);
		run_prog("illegal", 8, `NPC_RESET_PC + 64'h40, 5'd5, 64'd2);

		finish_run();
	end

endmodule

// ==== src.f ====
+incdir+.
npc_pkg.sv
npc_regfile.sv
npc_csr.sv
npc_ifu.sv
npc_exu.sv
npc_top.sv
npc_chk.sv
npc_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run npc_tb, pass if the log holds the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module npc_tb -f src.f -o npc_sim
	./obj_dir/npc_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
